/* compile.f */
source/exec_pkg.sv
source/exec_ifs.sv
source/arith_unit.sv
source/mult_pipe.sv
source/branch_resolve.sv
source/commit_latch.sv
source/ooo_execute.sv
test/tb_clock_gen.sv
test/ooo_execute_properties.sv
test/tb_ooo_execute.sv

/* Makefile */
# Verilator flow for the out-of-order execute stage
VERILATOR ?= verilator
TOP       ?= tb_ooo_execute
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/exec_trace.txt */
# iss unit op a b imm pc rd idx pred jreg flush stall | grp due data link rd idx taken mispred
# hex fields except due (decimal cycle); grp 0 none, 1 alu, 2 mult, 3 branch, 4 jump
1 0 0 00000005 00000003 00000000 00000000 01 1 0 0 0 0 1 1 00000008 00000000 01 1 0 0
1 0 1 00000003 00000005 00000000 00000000 02 2 0 0 0 0 1 2 fffffffe 00000000 02 2 0 0
1 0 2 f0f0f0f0 ff00ff00 00000000 00000000 03 3 0 0 0 0 1 3 f000f000 00000000 03 3 0 0
1 0 3 f0f0f0f0 ff00ff00 00000000 00000000 04 4 0 0 0 0 1 4 fff0fff0 00000000 04 4 0 0
1 0 4 f0f0f0f0 ff00ff00 00000000 00000000 05 5 0 0 0 0 1 5 0ff00ff0 00000000 05 5 0 0
1 0 5 00000001 00000024 00000000 00000000 06 6 0 0 0 0 1 6 00000010 00000000 06 6 0 0
1 0 6 80000000 00000004 00000000 00000000 07 7 0 0 0 0 1 7 08000000 00000000 07 7 0 0
1 0 7 80000000 00000004 00000000 00000000 08 0 0 0 0 0 1 8 f8000000 00000000 08 0 0 0
1 0 8 ffffffff 00000001 00000000 00000000 09 1 0 0 0 0 1 9 00000001 00000000 09 1 0 0
1 0 9 ffffffff 00000001 00000000 00000000 0a 2 0 0 0 0 1 10 00000000 00000000 0a 2 0 0
1 1 0 00000007 fffffffd 00000000 00000000 0b 3 0 0 0 0 2 14 ffffffeb 00000000 0b 3 0 0
1 1 1 fffffffe 00000003 00000000 00000000 0c 4 0 0 0 0 2 15 ffffffff 00000000 0c 4 0 0
1 1 2 fffffffe ffffffff 00000000 00000000 0d 5 0 0 0 0 2 16 fffffffe 00000000 0d 5 0 0
1 1 3 fffffffe ffffffff 00000000 00000000 0e 6 0 0 0 0 2 17 fffffffd 00000000 0e 6 0 0
1 2 0 00000005 00000005 00000040 00001000 00 0 1 0 0 0 3 15 00001040 00000000 00 0 1 0
1 2 1 00000005 00000005 00000040 00001000 00 0 1 0 0 0 3 16 00001004 00000000 00 0 0 1
1 2 2 ffffffff 00000001 00000040 00001000 00 0 0 0 0 0 3 17 00001040 00000000 00 0 1 1
1 2 3 ffffffff 00000001 00000040 00001000 00 0 0 0 0 0 3 18 00001004 00000000 00 0 0 0
1 2 4 ffffffff 00000001 00000040 00001000 00 0 1 0 0 0 3 19 00001004 00000000 00 0 0 1
1 2 5 ffffffff 00000001 fffffff0 00001000 00 0 1 0 0 0 3 20 00000ff0 00000000 00 0 1 0
1 3 0 00000000 00000000 00000100 00002000 01 7 0 0 0 0 4 21 00002100 00002004 01 7 0 0
1 3 0 00003001 00000000 00000002 00002100 1f 0 0 1 0 0 4 22 00003002 00002104 1f 0 0 0
1 1 0 00000003 00000004 00000000 00000000 02 1 0 0 0 0 0 0 00000000 00000000 00 0 0 0
1 1 0 00000005 00000006 00000000 00000000 03 2 0 0 0 0 0 0 00000000 00000000 00 0 0 0
1 0 0 00000001 00000001 00000000 00000000 04 3 0 0 1 0 0 0 00000000 00000000 00 0 0 0
1 1 3 00010000 00030000 00000000 00000000 10 2 0 0 0 0 2 31 00000003 00000000 10 2 0 0
1 0 0 00000100 00000023 00000000 00000000 11 3 0 0 0 0 1 27 00000123 00000000 11 3 0 0
0 0 0 00000000 00000000 00000000 00000000 00 0 0 0 0 1 1 28 00000123 00000000 11 3 0 0
0 0 0 00000000 00000000 00000000 00000000 00 0 0 0 0 1 1 29 00000123 00000000 11 3 0 0

/* test/tb_ooo_execute.sv */
// ================================================
// Execute stage testbench
// Replays the issue trace and checks every result
// group in the cycle where it is due
// ================================================
`default_nettype none

module tb_ooo_execute;
  timeunit 1ns;
  timeprecision 100ps;
  import exec_pkg::*;

  localparam int MULT_STAGES = 3;
  localparam int MAX_LINES   = 64;
  localparam int NUM_COLS    = 21;

  typedef struct packed {
    int        due;
    word_t     data;
    reg_idx_t  rd;
    cb_index_t idx;
    logic      taken;
    logic      mispredict;
  } expect_t;

  logic       CLK, nRST, issue, prediction, jump_reg, flush, stall;
  exec_unit_e unit;
  alu_op_e    alu_op;
  mult_op_e   mult_op;
  br_cond_e   br_cond;
  word_t      port_a, port_b, imm, pc;
  reg_idx_t   reg_rd, au_reg_rd, mu_reg_rd;
  cb_index_t  cb_index, au_index, mu_index;
  logic       au_wen, mu_wen, br_valid, br_taken, br_mispredict, jmp_valid;
  word_t      au_wdata, mu_wdata, br_resolved_addr, jmp_addr;

  logic [31:0] trace_mem [MAX_LINES][NUM_COLS];
  int          trace_len = 0;
  expect_t     au_q[$], mu_q[$], br_q[$], jmp_q[$];
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = MAX_LINES + MULT_STAGES + 20;

  tb_clock_gen clk0 (.CLK(CLK), .nRST(nRST));

  ooo_execute #(.MULT_STAGES(MULT_STAGES)) dut0 (.*);

  task automatic protocol_error(input string msg);
    $display("ERROR %s", msg);
    protocol_errors++;
  endtask

  task automatic check_wb(input string name, input word_t exp_data, input reg_idx_t exp_rd,
                          input cb_index_t exp_idx, input word_t act_data,
                          input reg_idx_t act_rd, input cb_index_t act_idx);
    if (act_data !== exp_data) begin
      $display("FAIL %s data: expected %h, actual %h", name, exp_data, act_data);
      value_errors++;
    end
    if (act_rd !== exp_rd) begin
      $display("FAIL %s reg_rd: expected %h, actual %h", name, exp_rd, act_rd);
      value_errors++;
    end
    if (act_idx !== exp_idx) begin
      $display("FAIL %s index: expected %h, actual %h", name, exp_idx, act_idx);
      value_errors++;
    end
  endtask

  task automatic check_branch(input string name, input logic exp_taken, input logic exp_mp,
                              input word_t exp_addr, input logic act_taken,
                              input logic act_mp, input word_t act_addr);
    if (act_taken !== exp_taken) begin
      $display("FAIL %s taken: expected %b, actual %b", name, exp_taken, act_taken);
      value_errors++;
    end
    if (act_mp !== exp_mp) begin
      $display("FAIL %s mispredict: expected %b, actual %b", name, exp_mp, act_mp);
      value_errors++;
    end
    if (act_addr !== exp_addr) begin
      $display("FAIL %s address: expected %h, actual %h", name, exp_addr, act_addr);
      value_errors++;
    end
  endtask

  task automatic check_addr(input string name, input word_t exp_addr, input word_t act_addr);
    if (act_addr !== exp_addr) begin
      $display("FAIL %s address: expected %h, actual %h", name, exp_addr, act_addr);
      value_errors++;
    end
  endtask

  // Each line is one cycle of stimulus plus at most one expected group
  task automatic load_trace();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [NUM_COLS];
    expect_t     e;
    fd = $fopen("test/exec_trace.txt", "r");
    if (fd == 0) begin
      protocol_error("cannot open the trace file test/exec_trace.txt");
      return;
    end
    while (!$feof(fd) && trace_len < MAX_LINES) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
      if (cnt != NUM_COLS) begin
        protocol_error($sformatf("trace line not understood: %s", line));
        continue;
      end
      for (int c = 0; c < NUM_COLS; c++) begin
        trace_mem[trace_len][c] = f[c];
      end
      e.due        = int'(f[14]);
      e.data       = f[15];
      e.rd         = f[17][REG_IDX_W-1:0];
      e.idx        = f[18][CB_INDEX_W-1:0];
      e.taken      = f[19][0];
      e.mispredict = f[20][0];
      case (f[13][2:0])
        3'd1: au_q.push_back(e);
        3'd2: mu_q.push_back(e);
        3'd3: br_q.push_back(e);
        3'd4: begin
          jmp_q.push_back(e);
          // Jump also writes its link value back
          e.data = f[16];
          au_q.push_back(e);
        end
        default: ;
      endcase
      trace_len++;
    end
    $fclose(fd);
  endtask

  task automatic drive_idle();
    issue      <= 1'b0;
    unit       <= ARITH;
    alu_op     <= ADD;
    mult_op    <= MUL;
    br_cond    <= BEQ;
    port_a     <= '0;
    port_b     <= '0;
    imm        <= '0;
    pc         <= '0;
    reg_rd     <= '0;
    cb_index   <= '0;
    prediction <= 1'b0;
    jump_reg   <= 1'b0;
    flush      <= 1'b0;
    stall      <= 1'b0;
  endtask

  // One op column feeds all three opcode inputs
  task automatic apply_line(input int k);
    issue      <= trace_mem[k][0][0];
    unit       <= exec_unit_e'(trace_mem[k][1][1:0]);
    alu_op     <= alu_op_e'(trace_mem[k][2][3:0]);
    mult_op    <= mult_op_e'(trace_mem[k][2][1:0]);
    br_cond    <= br_cond_e'(trace_mem[k][2][2:0]);
    port_a     <= trace_mem[k][3];
    port_b     <= trace_mem[k][4];
    imm        <= trace_mem[k][5];
    pc         <= trace_mem[k][6];
    reg_rd     <= trace_mem[k][7][REG_IDX_W-1:0];
    cb_index   <= trace_mem[k][8][CB_INDEX_W-1:0];
    prediction <= trace_mem[k][9][0];
    jump_reg   <= trace_mem[k][10][0];
    flush      <= trace_mem[k][11][0];
    stall      <= trace_mem[k][12][0];
  endtask

  task automatic check_reset_values();
    if (au_wen || mu_wen || br_valid || jmp_valid)
      protocol_error("a valid output is high during reset");
    if ({au_wdata, au_reg_rd, au_index, mu_wdata, mu_reg_rd, mu_index, br_taken,
         br_mispredict, br_resolved_addr, jmp_addr} !== '0)
      protocol_error("a data output is not zero during reset");
  endtask

  // A valid without a due entry, or a due entry without its valid, is an error
  task automatic check_cycle(input int cyc);
    expect_t e;
    string   at;
    at = $sformatf("at cycle %0d", cyc);
    if (au_q.size() > 0 && au_q[0].due == cyc) begin
      e = au_q.pop_front();
      if (!au_wen) protocol_error({"alu writeback missing ", at});
      else check_wb({"alu ", at}, e.data, e.rd, e.idx, au_wdata, au_reg_rd, au_index);
    end else if (au_wen) begin
      protocol_error({"unexpected alu writeback ", at});
    end
    if (mu_q.size() > 0 && mu_q[0].due == cyc) begin
      e = mu_q.pop_front();
      if (!mu_wen) protocol_error({"multiply writeback missing ", at});
      else check_wb({"mult ", at}, e.data, e.rd, e.idx, mu_wdata, mu_reg_rd, mu_index);
    end else if (mu_wen) begin
      protocol_error({"unexpected multiply writeback ", at});
    end
    if (br_q.size() > 0 && br_q[0].due == cyc) begin
      e = br_q.pop_front();
      if (!br_valid) protocol_error({"branch outcome missing ", at});
      else check_branch({"branch ", at}, e.taken, e.mispredict, e.data,
                        br_taken, br_mispredict, br_resolved_addr);
    end else if (br_valid) begin
      protocol_error({"unexpected branch outcome ", at});
    end
    if (jmp_q.size() > 0 && jmp_q[0].due == cyc) begin
      e = jmp_q.pop_front();
      if (!jmp_valid) protocol_error({"jump outcome missing ", at});
      else check_addr({"jump ", at}, e.data, jmp_addr);
    end else if (jmp_valid) begin
      protocol_error({"unexpected jump outcome ", at});
    end
  endtask

  task automatic finish_run();
    int assert_errors;
    assert_errors = dut0.props0.fail_count;
    if (au_q.size() + mu_q.size() + br_q.size() + jmp_q.size() != 0)
      protocol_error("expected results were never seen");
    $display("Errors: %0d value, %0d protocol, %0d assertion",
             value_errors, protocol_errors, assert_errors);
    if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not end within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    drive_idle();
    load_trace();
    cycle_limit = trace_len + MULT_STAGES + 20;
    @(negedge CLK);
    check_reset_values();
    wait (nRST === 1'b1);
    // Drain cycles let the last multiply reach the outputs
    for (int j = 0; j < trace_len + MULT_STAGES + 4; j++) begin
      @(posedge CLK);
      if (j < trace_len) apply_line(j);
      else drive_idle();
      @(negedge CLK);
      check_cycle(j);
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* test/ooo_execute_properties.sv */
// ================================================
// Execute stage assertions
// Bound to the top level, checks output qualifiers
// ================================================
`default_nettype none

module ooo_execute_properties (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic stall,
  input logic au_wen,
  input logic mu_wen,
  input logic br_valid,
  input logic jmp_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // A branch never writes a register
  branch_no_writeback: assert property (
    @(posedge CLK) disable iff (!nRST) !(au_wen && br_valid)
  ) else begin
    $error("au_wen and br_valid high in the same cycle");
    fail_count++;
  end

  flush_clears_valids: assert property (
    @(posedge CLK) disable iff (!nRST)
    flush |=> !(au_wen || mu_wen || br_valid || jmp_valid)
  ) else begin
    $error("a valid output is high in the cycle after flush");
    fail_count++;
  end

  // Flush wins over stall, so only a plain stall must hold
  stall_holds_valids: assert property (
    @(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> $stable({au_wen, mu_wen, br_valid, jmp_valid})
  ) else begin
    $error("a valid output changed during stall");
    fail_count++;
  end

endmodule

bind ooo_execute ooo_execute_properties props0 (
  .CLK(CLK), .nRST(nRST), .flush(flush), .stall(stall),
  .au_wen(au_wen), .mu_wen(mu_wen), .br_valid(br_valid), .jmp_valid(jmp_valid)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
// ================================================
// Testbench clock and reset
// 20 ns clock, active low reset for a few cycles
// ================================================
`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 4
) (
  output logic CLK,
  output logic nRST
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Release on a rising edge so the first edge out of reset is clean
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
  end

endmodule

`default_nettype wire

/* source/ooo_execute.sv */
// ================================================
// Out-of-order execute stage
// ALU, multiplier and branch units feeding the commit latch
// ================================================
`default_nettype none

module ooo_execute #(
  parameter int MULT_STAGES = 3
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 issue,
  input  exec_pkg::exec_unit_e unit,
  input  exec_pkg::alu_op_e    alu_op,
  input  exec_pkg::mult_op_e   mult_op,
  input  exec_pkg::br_cond_e   br_cond,
  input  exec_pkg::word_t      port_a,
  input  exec_pkg::word_t      port_b,
  input  exec_pkg::word_t      imm,
  input  exec_pkg::word_t      pc,
  input  exec_pkg::reg_idx_t   reg_rd,
  input  exec_pkg::cb_index_t  cb_index,
  input  logic                 prediction,
  input  logic                 jump_reg,
  input  logic                 flush,
  input  logic                 stall,
  output logic                 au_wen,
  output exec_pkg::word_t      au_wdata,
  output exec_pkg::reg_idx_t   au_reg_rd,
  output exec_pkg::cb_index_t  au_index,
  output logic                 mu_wen,
  output exec_pkg::word_t      mu_wdata,
  output exec_pkg::reg_idx_t   mu_reg_rd,
  output exec_pkg::cb_index_t  mu_index,
  output logic                 br_valid,
  output logic                 br_taken,
  output logic                 br_mispredict,
  output exec_pkg::word_t      br_resolved_addr,
  output logic                 jmp_valid,
  output exec_pkg::word_t      jmp_addr
);

  wb_if au_bus ();
  wb_if mu_bus ();
  br_if br_bus ();

  arith_unit arith0 (
    .issue(issue), .unit(unit), .alu_op(alu_op),
    .port_a(port_a), .port_b(port_b), .pc(pc),
    .reg_rd(reg_rd), .cb_index(cb_index), .res(au_bus.producer)
  );

  mult_pipe #(.MULT_STAGES(MULT_STAGES)) mult0 (
    .CLK(CLK), .nRST(nRST), .issue(issue), .unit(unit), .mult_op(mult_op),
    .port_a(port_a), .port_b(port_b), .reg_rd(reg_rd), .cb_index(cb_index),
    .flush(flush), .stall(stall), .res(mu_bus.producer)
  );

  branch_resolve bres0 (
    .issue(issue), .unit(unit), .br_cond(br_cond),
    .port_a(port_a), .port_b(port_b), .imm(imm), .pc(pc),
    .prediction(prediction), .jump_reg(jump_reg), .res(br_bus.producer)
  );

  commit_latch latch0 (
    .CLK(CLK), .nRST(nRST), .flush(flush), .stall(stall),
    .au(au_bus.latch), .mu(mu_bus.latch), .br(br_bus.latch),
    .au_wen(au_wen), .au_wdata(au_wdata), .au_reg_rd(au_reg_rd), .au_index(au_index),
    .mu_wen(mu_wen), .mu_wdata(mu_wdata), .mu_reg_rd(mu_reg_rd), .mu_index(mu_index),
    .br_valid(br_valid), .br_taken(br_taken), .br_mispredict(br_mispredict),
    .br_resolved_addr(br_resolved_addr),
    .jmp_valid(jmp_valid), .jmp_addr(jmp_addr)
  );

endmodule

`default_nettype wire

/* source/commit_latch.sv */
// ================================================
// Execute to commit latch
// Registers all results, with flush and stall control
// ================================================
`default_nettype none

module commit_latch (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                flush,
  input  logic                stall,
  wb_if.latch                 au,
  wb_if.latch                 mu,
  br_if.latch                 br,
  output logic                au_wen,
  output exec_pkg::word_t     au_wdata,
  output exec_pkg::reg_idx_t  au_reg_rd,
  output exec_pkg::cb_index_t au_index,
  output logic                mu_wen,
  output exec_pkg::word_t     mu_wdata,
  output exec_pkg::reg_idx_t  mu_reg_rd,
  output exec_pkg::cb_index_t mu_index,
  output logic                br_valid,
  output logic                br_taken,
  output logic                br_mispredict,
  output exec_pkg::word_t     br_resolved_addr,
  output logic                jmp_valid,
  output exec_pkg::word_t     jmp_addr
);

  // Priority is reset, flush, stall, then load
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      au_wen           <= 1'b0;
      au_wdata         <= '0;
      au_reg_rd        <= '0;
      au_index         <= '0;
      mu_wen           <= 1'b0;
      mu_wdata         <= '0;
      mu_reg_rd        <= '0;
      mu_index         <= '0;
      br_valid         <= 1'b0;
      br_taken         <= 1'b0;
      br_mispredict    <= 1'b0;
      br_resolved_addr <= '0;
      jmp_valid        <= 1'b0;
      jmp_addr         <= '0;
    end else if (flush) begin
      // Only the qualifiers drop, payload is left as is
      au_wen    <= 1'b0;
      mu_wen    <= 1'b0;
      br_valid  <= 1'b0;
      jmp_valid <= 1'b0;
    end else if (!stall) begin
      au_wen           <= au.wen;
      au_wdata         <= au.wdata;
      au_reg_rd        <= au.reg_rd;
      au_index         <= au.index;
      mu_wen           <= mu.wen;
      mu_wdata         <= mu.wdata;
      mu_reg_rd        <= mu.reg_rd;
      mu_index         <= mu.index;
      br_valid         <= br.br_valid;
      br_taken         <= br.taken;
      br_mispredict    <= br.mispredict;
      br_resolved_addr <= br.resolved_addr;
      jmp_valid        <= br.jmp_valid;
      jmp_addr         <= br.jmp_addr;
    end
  end

endmodule

`default_nettype wire

/* source/branch_resolve.sv */
// ================================================
// Branch and jump resolution
// Condition check, target address and mispredict flag
// ================================================
`default_nettype none

module branch_resolve (
  input  logic                 issue,
  input  exec_pkg::exec_unit_e unit,
  input  exec_pkg::br_cond_e   br_cond,
  input  exec_pkg::word_t      port_a,
  input  exec_pkg::word_t      port_b,
  input  exec_pkg::word_t      imm,
  input  exec_pkg::word_t      pc,
  input  logic                 prediction,
  input  logic                 jump_reg,
  br_if.producer               res
);
  import exec_pkg::*;

  logic  taken;
  word_t pc4;
  word_t pc_target;
  word_t reg_target;

  always_comb begin
    case (br_cond)
      BEQ:     taken = (port_a == port_b);
      BNE:     taken = (port_a != port_b);
      BLT:     taken = ($signed(port_a) < $signed(port_b));
      BGE:     taken = ($signed(port_a) >= $signed(port_b));
      BLTU:    taken = (port_a < port_b);
      BGEU:    taken = (port_a >= port_b);
      default: taken = 1'b0;
    endcase
  end

  assign pc4        = pc + word_t'(4);
  assign pc_target  = pc + imm;
  assign reg_target = port_a + imm;

  // Fall through to pc + 4 when not taken
  assign res.br_valid      = issue && (unit == BRANCH);
  assign res.taken         = taken;
  assign res.mispredict    = (prediction != taken);
  assign res.resolved_addr = taken ? pc_target : pc4;

  // Register-relative jumps drop bit 0 of the sum
  assign res.jmp_valid = issue && (unit == JUMP);
  assign res.jmp_addr  = jump_reg ? {reg_target[WORD_W-1:1], 1'b0} : pc_target;

endmodule

`default_nettype wire

/* source/mult_pipe.sv */
// ================================================
// Pipelined multiplier
// Product and destination tags move through the stages together
// ================================================
`default_nettype none

module mult_pipe #(
  parameter int MULT_STAGES = 3
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 issue,
  input  exec_pkg::exec_unit_e unit,
  input  exec_pkg::mult_op_e   mult_op,
  input  exec_pkg::word_t      port_a,
  input  exec_pkg::word_t      port_b,
  input  exec_pkg::reg_idx_t   reg_rd,
  input  exec_pkg::cb_index_t  cb_index,
  input  logic                 flush,
  input  logic                 stall,
  wb_if.producer               res
);
  import exec_pkg::*;

  localparam int LAST = MULT_STAGES - 1;

  logic                     a_signed;
  logic                     b_signed;
  logic [WORD_W:0]          a_ext;
  logic [WORD_W:0]          b_ext;
  logic signed [2*WORD_W+1:0] full_product;
  logic                     load;

  logic [MULT_STAGES-1:0]   valid_q;
  logic [2*WORD_W-1:0]      prod_q [MULT_STAGES];
  mult_op_e                 op_q   [MULT_STAGES];
  reg_idx_t                 rd_q   [MULT_STAGES];
  cb_index_t                idx_q  [MULT_STAGES];

  // One extra bit per operand covers all signedness cases
  assign a_signed     = (mult_op == MULH) || (mult_op == MULHSU);
  assign b_signed     = (mult_op == MULH);
  assign a_ext        = {a_signed & port_a[WORD_W-1], port_a};
  assign b_ext        = {b_signed & port_b[WORD_W-1], port_b};
  assign full_product = $signed(a_ext) * $signed(b_ext);
  assign load         = issue && (unit == MULT);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
      for (int i = 0; i < MULT_STAGES; i++) begin
        prod_q[i] <= '0;
        op_q[i]   <= MUL;
        rd_q[i]   <= '0;
        idx_q[i]  <= '0;
      end
    end else if (flush) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q[0] <= load;
      prod_q[0]  <= full_product[2*WORD_W-1:0];
      op_q[0]    <= mult_op;
      rd_q[0]    <= reg_rd;
      idx_q[0]   <= cb_index;
      for (int i = 1; i < MULT_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
        prod_q[i]  <= prod_q[i-1];
        op_q[i]    <= op_q[i-1];
        rd_q[i]    <= rd_q[i-1];
        idx_q[i]   <= idx_q[i-1];
      end
    end
  end

  // Low word for MUL, high word for the MULH variants
  assign res.wen    = valid_q[LAST];
  assign res.wdata  = (op_q[LAST] == MUL) ? prod_q[LAST][WORD_W-1:0]
                                          : prod_q[LAST][2*WORD_W-1:WORD_W];
  assign res.reg_rd = rd_q[LAST];
  assign res.index  = idx_q[LAST];

endmodule

`default_nettype wire

/* source/arith_unit.sv */
// ================================================
// Arithmetic unit
// Single-cycle ALU, also produces the jump link value
// ================================================
`default_nettype none

module arith_unit (
  input  logic                 issue,
  input  exec_pkg::exec_unit_e unit,
  input  exec_pkg::alu_op_e    alu_op,
  input  exec_pkg::word_t      port_a,
  input  exec_pkg::word_t      port_b,
  input  exec_pkg::word_t      pc,
  input  exec_pkg::reg_idx_t   reg_rd,
  input  exec_pkg::cb_index_t  cb_index,
  wb_if.producer               res
);
  import exec_pkg::*;

  word_t      alu_result;
  logic [4:0] shamt;

  // RV32 shifts only look at the low 5 bits
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ADD:     alu_result = port_a + port_b;
      SUB:     alu_result = port_a - port_b;
      AND:     alu_result = port_a & port_b;
      OR:      alu_result = port_a | port_b;
      XOR:     alu_result = port_a ^ port_b;
      SLL:     alu_result = port_a << shamt;
      SRL:     alu_result = port_a >> shamt;
      SRA:     alu_result = $signed(port_a) >>> shamt;
      SLT:     alu_result = {{(WORD_W-1){1'b0}}, $signed(port_a) < $signed(port_b)};
      SLTU:    alu_result = {{(WORD_W-1){1'b0}}, port_a < port_b};
      default: alu_result = '0;
    endcase
  end

  // Jumps write the return address instead of an ALU result
  assign res.wen    = issue && ((unit == ARITH) || (unit == JUMP));
  assign res.wdata  = (unit == JUMP) ? pc + word_t'(4) : alu_result;
  assign res.reg_rd = reg_rd;
  assign res.index  = cb_index;

endmodule

`default_nettype wire

/* source/exec_ifs.sv */
// ================================================
// Execute stage result interfaces
// Writeback group and branch/jump outcome group
// ================================================
`default_nettype none

// Fields are valid in the cycle where wen is high
interface wb_if;
  import exec_pkg::*;

  logic      wen;
  word_t     wdata;
  reg_idx_t  reg_rd;
  cb_index_t index;

  modport producer (output wen, wdata, reg_rd, index);
  modport latch    (input  wen, wdata, reg_rd, index);
endinterface

// Branch fields qualified by br_valid, jump fields by jmp_valid
interface br_if;
  import exec_pkg::*;

  logic  br_valid;
  logic  taken;
  logic  mispredict;
  word_t resolved_addr;
  logic  jmp_valid;
  word_t jmp_addr;

  modport producer (output br_valid, taken, mispredict, resolved_addr, jmp_valid, jmp_addr);
  modport latch    (input  br_valid, taken, mispredict, resolved_addr, jmp_valid, jmp_addr);
endinterface

`default_nettype wire

/* source/exec_pkg.sv */
// ================================================
// Execute stage shared definitions
// Data word, register tag and opcode types
// ================================================
`default_nettype none

package exec_pkg;

  parameter int WORD_W     = 32;
  parameter int REG_IDX_W  = 5;
  parameter int CB_INDEX_W = 3;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;
  typedef logic [CB_INDEX_W-1:0] cb_index_t;

  // Target unit of an issued instruction
  typedef enum logic [1:0] {
    ARITH  = 2'd0,
    MULT   = 2'd1,
    BRANCH = 2'd2,
    JUMP   = 2'd3
  } exec_unit_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_e;

  // High word variants differ only in operand signedness
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd2,
    BGE  = 3'd3,
    BLTU = 3'd4,
    BGEU = 3'd5
  } br_cond_e;

endpackage

`default_nettype wire
